// ==== source/kavach_pkg.sv ====
package kavach_pkg;

    // ==============================
    // Score type and ceiling
    // ==============================

    // Threat score, unsigned
    typedef logic [7:0] score_t;

    // Saturation ceiling of the weighted sum
    localparam score_t SCORE_MAX = 8'd255;

    // ==============================
    // Level and attack encodings
    // ==============================

    // Reported threat level, 3 bits
    typedef enum logic [2:0] {
        LVL_NONE     = 3'd0,
        LVL_LOW      = 3'd1,
        LVL_MEDIUM   = 3'd2,
        LVL_HIGH     = 3'd3,
        LVL_CRITICAL = 3'd4
    } threat_level_e;

    // Attack classification, 4 bits
    typedef enum logic [3:0] {
        AT_NONE       = 4'd0,
        AT_PWR_GLITCH = 4'd1,
        AT_CLK_ATTACK = 4'd2,
        AT_THERMAL    = 4'd3,
        AT_FAULT_INJ  = 4'd4,
        AT_SIDE_CH    = 4'd5,
        AT_COMBINED   = 4'd6
    } attack_type_e;

    // ==============================
    // Anomaly flag word
    // ==============================

    // Named flags, volt at the MSB
    typedef struct packed {
        logic volt;
        logic curr;
        logic glitch;
        logic clk_glitch;
        logic freq_drift;
        logic temp_hi;
        logic temp_lo;
        logic temp_roc;
        logic ipc;
        logic pc_jump;
        logic priv;
        logic mem_oob;
        logic flush;
        logic nmi;
    } anomaly_flags_t;

    // Flat view for reductions, named view for decode
    typedef union packed {
        logic [13:0]    bits;
        anomaly_flags_t f;
    } anomaly_word_u;

    // ==============================
    // Score weights
    // ==============================

    // Critical flags
    localparam score_t W_PRIV       = 8'd40;
    localparam score_t W_GLITCH     = 8'd30;
    localparam score_t W_CLK_GLITCH = 8'd25;
    // Medium flags
    localparam score_t W_PC_JUMP    = 8'd20;
    localparam score_t W_MEM_OOB    = 8'd20;
    localparam score_t W_NMI        = 8'd15;
    // Low flags
    localparam score_t W_VOLT       = 8'd10;
    localparam score_t W_CURR       = 8'd10;
    localparam score_t W_TEMP_HI    = 8'd10;
    localparam score_t W_TEMP_LO    = 8'd10;
    localparam score_t W_FREQ       = 8'd8;
    localparam score_t W_IPC        = 8'd8;
    localparam score_t W_FLUSH      = 8'd5;
    localparam score_t W_TEMP_ROC   = 8'd5;
    // Fusion engine qualifiers
    localparam score_t W_CORRELATED = 8'd35;
    localparam score_t W_MULTI      = 8'd15;

endpackage

// ==== source/anomaly_if.sv ====
`timescale 1ns/1ps

interface anomaly_if;

    // Per-cycle monitor flags and fusion results
    kavach_pkg::anomaly_word_u flags;
    kavach_pkg::score_t        fused_score;
    logic                      correlated_attack;
    logic                      multi_domain_alert;

    // Top level drives everything
    modport source (output flags, fused_score, correlated_attack, multi_domain_alert);

    // Weighted sum needs the whole bundle
    modport scorer (input flags, fused_score, correlated_attack, multi_domain_alert);

    // Classification ignores the fused score
    modport typer (input flags, correlated_attack, multi_domain_alert);

    // State machine overrides only
    modport fsm (input flags, correlated_attack);

endinterface

// ==== source/threat_scorer.sv ====
`timescale 1ns/1ps

module threat_scorer (
    input  logic               clk,
    input  logic               rst_n,
    anomaly_if.scorer          anom,
    output kavach_pkg::score_t score
);

    // Worst case 255 + 266 of weights, fits in 10 bits
    localparam int SUM_W = 10;

    logic [SUM_W-1:0]   sum;
    kavach_pkg::score_t score_d;

    // ==============================
    // Weighted sum
    // ==============================

    always_comb begin
        // Base from the averaging engine
        sum = SUM_W'(anom.fused_score);
        // Critical flags
        sum = sum + (anom.flags.f.priv       ? SUM_W'(kavach_pkg::W_PRIV)       : '0);
        sum = sum + (anom.flags.f.glitch     ? SUM_W'(kavach_pkg::W_GLITCH)     : '0);
        sum = sum + (anom.flags.f.clk_glitch ? SUM_W'(kavach_pkg::W_CLK_GLITCH) : '0);
        // Medium flags
        sum = sum + (anom.flags.f.pc_jump    ? SUM_W'(kavach_pkg::W_PC_JUMP)    : '0);
        sum = sum + (anom.flags.f.mem_oob    ? SUM_W'(kavach_pkg::W_MEM_OOB)    : '0);
        sum = sum + (anom.flags.f.nmi        ? SUM_W'(kavach_pkg::W_NMI)        : '0);
        // Low flags
        sum = sum + (anom.flags.f.volt       ? SUM_W'(kavach_pkg::W_VOLT)       : '0);
        sum = sum + (anom.flags.f.curr       ? SUM_W'(kavach_pkg::W_CURR)       : '0);
        sum = sum + (anom.flags.f.temp_hi    ? SUM_W'(kavach_pkg::W_TEMP_HI)    : '0);
        sum = sum + (anom.flags.f.temp_lo    ? SUM_W'(kavach_pkg::W_TEMP_LO)    : '0);
        sum = sum + (anom.flags.f.freq_drift ? SUM_W'(kavach_pkg::W_FREQ)       : '0);
        sum = sum + (anom.flags.f.ipc        ? SUM_W'(kavach_pkg::W_IPC)        : '0);
        sum = sum + (anom.flags.f.flush      ? SUM_W'(kavach_pkg::W_FLUSH)      : '0);
        sum = sum + (anom.flags.f.temp_roc   ? SUM_W'(kavach_pkg::W_TEMP_ROC)   : '0);
        // Fusion qualifiers
        sum = sum + (anom.correlated_attack  ? SUM_W'(kavach_pkg::W_CORRELATED) : '0);
        sum = sum + (anom.multi_domain_alert ? SUM_W'(kavach_pkg::W_MULTI)      : '0);

        // Clamp instead of wrapping
        if (sum > SUM_W'(kavach_pkg::SCORE_MAX)) begin
            score_d = kavach_pkg::SCORE_MAX;
        end else begin
            score_d = sum[7:0];
        end
    end

    // One cycle after the inputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            score <= '0;
        end else begin
            score <= score_d;
        end
    end

endmodule

// ==== source/attack_typer.sv ====
`timescale 1ns/1ps

module attack_typer (
    input  logic                     clk,
    input  logic                     rst_n,
    anomaly_if.typer                 anom,
    output kavach_pkg::attack_type_e attack_type
);

    kavach_pkg::attack_type_e type_d;

    // ==============================
    // Priority classification
    // ==============================

    always_comb begin
        // Coordinated attack wins over any single domain
        if (anom.correlated_attack || anom.multi_domain_alert) begin
            type_d = kavach_pkg::AT_COMBINED;
        end
        // Execution-level tampering
        else if (anom.flags.f.priv || anom.flags.f.pc_jump) begin
            type_d = kavach_pkg::AT_FAULT_INJ;
        end
        // Supply glitch, or voltage and current both off
        else if (anom.flags.f.glitch || (anom.flags.f.volt && anom.flags.f.curr)) begin
            type_d = kavach_pkg::AT_PWR_GLITCH;
        end
        // Clock manipulation
        else if (anom.flags.f.clk_glitch || anom.flags.f.freq_drift) begin
            type_d = kavach_pkg::AT_CLK_ATTACK;
        end
        // Laser heating or cryo
        else if (anom.flags.f.temp_hi || anom.flags.f.temp_lo) begin
            type_d = kavach_pkg::AT_THERMAL;
        end
        // IPC deviation alone
        else if (anom.flags.f.ipc) begin
            type_d = kavach_pkg::AT_SIDE_CH;
        end
        else begin
            type_d = kavach_pkg::AT_NONE;
        end
    end

    // Aligned with the score register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            attack_type <= kavach_pkg::AT_NONE;
        end else begin
            attack_type <= type_d;
        end
    end

endmodule

// ==== source/threat_level_fsm.sv ====
`timescale 1ns/1ps

module threat_level_fsm #(
    parameter kavach_pkg::score_t SCORE_LOW      = 8'd20,
    parameter kavach_pkg::score_t SCORE_MEDIUM   = 8'd60,
    parameter kavach_pkg::score_t SCORE_HIGH     = 8'd120,
    parameter kavach_pkg::score_t SCORE_CRITICAL = 8'd200,
    parameter int unsigned        HOLD_CYCLES    = 16
) (
    input  logic                      clk,
    input  logic                      rst_n,
    anomaly_if.fsm                    anom,
    input  kavach_pkg::score_t        score,
    output kavach_pkg::threat_level_e threat_level,
    output logic                      threat_valid,
    output logic                      threat_upgraded,
    output logic                      threat_cleared
);

    // Wide enough for HOLD_CYCLES, at least one bit
    localparam int CNT_W = $clog2(HOLD_CYCLES + 2);

    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_LOW      = 3'd1,
        ST_MEDIUM   = 3'd2,
        ST_HIGH     = 3'd3,
        ST_CRITICAL = 3'd4,
        ST_HOLD     = 3'd5
    } state_e;

    state_e                    state;
    state_e                    state_d;
    logic [CNT_W-1:0]          hold_cnt;
    logic                      any_anomaly;
    kavach_pkg::threat_level_e level_d;

    // Flat view of the flag word
    assign any_anomaly = |anom.flags.bits;

    // ==============================
    // Next state
    // ==============================

    always_comb begin
        state_d = state;
        case (state)
            ST_IDLE: begin
                // priv escalates straight to the top
                if (score >= SCORE_CRITICAL || anom.flags.f.priv) state_d = ST_CRITICAL;
                else if (score >= SCORE_HIGH)                     state_d = ST_HIGH;
                else if (score >= SCORE_MEDIUM)                   state_d = ST_MEDIUM;
                else if (score >= SCORE_LOW)                      state_d = ST_LOW;
            end
            ST_LOW: begin
                if (score >= SCORE_CRITICAL)    state_d = ST_CRITICAL;
                else if (score >= SCORE_HIGH)   state_d = ST_HIGH;
                else if (score >= SCORE_MEDIUM) state_d = ST_MEDIUM;
                else if (score < SCORE_LOW)     state_d = ST_HOLD;
            end
            ST_MEDIUM: begin
                if (score >= SCORE_CRITICAL)    state_d = ST_CRITICAL;
                else if (score >= SCORE_HIGH)   state_d = ST_HIGH;
                else if (score < SCORE_MEDIUM)  state_d = ST_HOLD;
            end
            ST_HIGH: begin
                if (score >= SCORE_CRITICAL || anom.correlated_attack) state_d = ST_CRITICAL;
                else if (score < SCORE_HIGH)                           state_d = ST_HOLD;
            end
            ST_CRITICAL: begin
                // Leave only once every monitor is quiet
                if (score < SCORE_HIGH && !any_anomaly) state_d = ST_HOLD;
            end
            ST_HOLD: begin
                if (score >= SCORE_CRITICAL)                  state_d = ST_CRITICAL;
                else if (score >= SCORE_HIGH)                 state_d = ST_HIGH;
                else if (hold_cnt >= CNT_W'(HOLD_CYCLES))     state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // State register and hold timer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            hold_cnt <= '0;
        end else begin
            state <= state_d;
            // Counts only while holding
            if (state == ST_HOLD) hold_cnt <= hold_cnt + 1'b1;
            else                  hold_cnt <= '0;
        end
    end

    // ==============================
    // Output register
    // ==============================

    // Level seen by the response side
    always_comb begin
        case (state)
            ST_LOW:      level_d = kavach_pkg::LVL_LOW;
            ST_MEDIUM:   level_d = kavach_pkg::LVL_MEDIUM;
            ST_HIGH:     level_d = kavach_pkg::LVL_HIGH;
            ST_CRITICAL: level_d = kavach_pkg::LVL_CRITICAL;
            ST_HOLD:     level_d = threat_level; // Keep last reported level
            default:     level_d = kavach_pkg::LVL_NONE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            threat_level    <= kavach_pkg::LVL_NONE;
            threat_valid    <= 1'b0;
            threat_upgraded <= 1'b0;
            threat_cleared  <= 1'b0;
        end else begin
            threat_level <= level_d;
            // Active only in a live level state
            threat_valid <= (state != ST_IDLE) && (state != ST_HOLD);
            // Edges against the level currently on the output
            threat_upgraded <= (level_d > threat_level);
            threat_cleared  <= (level_d == kavach_pkg::LVL_NONE) &&
                               (threat_level != kavach_pkg::LVL_NONE);
        end
    end

endmodule

// ==== source/threat_classifier_top.sv ====
`timescale 1ns/1ps

module threat_classifier_top #(
    parameter kavach_pkg::score_t SCORE_LOW      = 8'd20,
    parameter kavach_pkg::score_t SCORE_MEDIUM   = 8'd60,
    parameter kavach_pkg::score_t SCORE_HIGH     = 8'd120,
    parameter kavach_pkg::score_t SCORE_CRITICAL = 8'd200,
    parameter int unsigned        HOLD_CYCLES    = 16
) (
    input  logic                      clk,
    input  logic                      rst_n,
    // Monitor flags
    input  logic                      volt_anomaly,
    input  logic                      curr_anomaly,
    input  logic                      glitch_detected,
    input  logic                      clk_glitch,
    input  logic                      freq_drift,
    input  logic                      temp_hi_anomaly,
    input  logic                      temp_lo_anomaly,
    input  logic                      temp_roc_alert,
    input  logic                      ipc_anomaly,
    input  logic                      pc_jump_anomaly,
    input  logic                      priv_anomaly,
    input  logic                      mem_oob_anomaly,
    input  logic                      flush_anomaly,
    input  logic                      nmi_anomaly,
    // Fusion engine
    input  kavach_pkg::score_t        fused_score,
    input  logic                      correlated_attack,
    input  logic                      multi_domain_alert,
    // Classification
    output kavach_pkg::threat_level_e threat_level,
    output kavach_pkg::attack_type_e  attack_type,
    output kavach_pkg::score_t        threat_score,
    output logic                      threat_valid,
    output logic                      threat_upgraded,
    output logic                      threat_cleared
);

    anomaly_if anom_bus ();

    // Pack flags by name into the shared word
    assign anom_bus.flags.f = '{
        volt:       volt_anomaly,
        curr:       curr_anomaly,
        glitch:     glitch_detected,
        clk_glitch: clk_glitch,
        freq_drift: freq_drift,
        temp_hi:    temp_hi_anomaly,
        temp_lo:    temp_lo_anomaly,
        temp_roc:   temp_roc_alert,
        ipc:        ipc_anomaly,
        pc_jump:    pc_jump_anomaly,
        priv:       priv_anomaly,
        mem_oob:    mem_oob_anomaly,
        flush:      flush_anomaly,
        nmi:        nmi_anomaly
    };
    assign anom_bus.fused_score        = fused_score;
    assign anom_bus.correlated_attack  = correlated_attack;
    assign anom_bus.multi_domain_alert = multi_domain_alert;

    // Registered score, also feeds the FSM
    threat_scorer u_scorer (
        .clk   (clk),
        .rst_n (rst_n),
        .anom  (anom_bus.scorer),
        .score (threat_score)
    );

    attack_typer u_typer (
        .clk         (clk),
        .rst_n       (rst_n),
        .anom        (anom_bus.typer),
        .attack_type (attack_type)
    );

    threat_level_fsm #(
        .SCORE_LOW      (SCORE_LOW),
        .SCORE_MEDIUM   (SCORE_MEDIUM),
        .SCORE_HIGH     (SCORE_HIGH),
        .SCORE_CRITICAL (SCORE_CRITICAL),
        .HOLD_CYCLES    (HOLD_CYCLES)
    ) u_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .anom            (anom_bus.fsm),
        .score           (threat_score),
        .threat_level    (threat_level),
        .threat_valid    (threat_valid),
        .threat_upgraded (threat_upgraded),
        .threat_cleared  (threat_cleared)
    );

endmodule

// ==== tb/threat_classifier_assert.sv ====
`timescale 1ns/1ps

module threat_classifier_assert (
    input logic                      clk,
    input logic                      rst_n,
    input kavach_pkg::threat_level_e threat_level,
    input kavach_pkg::attack_type_e  attack_type,
    input logic                      threat_valid,
    input logic                      threat_upgraded,
    input logic                      threat_cleared
);

    // ==============================
    // Output sanity
    // ==============================

    // A level cannot rise and clear at once
    upgrade_clear_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(threat_upgraded && threat_cleared)
    ) else $error("threat_upgraded and threat_cleared high in the same cycle");

    // Codes past COMBINED are unused
    attack_code_range: assert property (
        @(posedge clk) disable iff (!rst_n) attack_type <= kavach_pkg::AT_COMBINED
    ) else $error("attack_type above COMBINED");

    // Live threat implies a reported level
    valid_needs_level: assert property (
        @(posedge clk) disable iff (!rst_n)
            !(threat_valid && threat_level == kavach_pkg::LVL_NONE)
    ) else $error("threat_valid high while threat_level is NONE");

endmodule

// ==== tb/tb_threat_classifier.sv ====
`timescale 1ns/1ps

module tb_threat_classifier;

    typedef kavach_pkg::anomaly_flags_t flags_t;

    logic                      clk;
    logic                      rst_n;
    flags_t                    flags;
    kavach_pkg::score_t        fused_score;
    logic                      correlated_attack;
    logic                      multi_domain_alert;
    kavach_pkg::threat_level_e threat_level;
    kavach_pkg::attack_type_e  attack_type;
    kavach_pkg::score_t        threat_score;
    logic                      threat_valid;
    logic                      threat_upgraded;
    logic                      threat_cleared;

    // Inputs seen at the previous negedge
    flags_t                    prev_flags;
    kavach_pkg::score_t        prev_fused;
    logic                      prev_corr;
    logic                      prev_multi;
    logic                      prev_ok = 1'b0;
    int                        errors = 0;
    int                        checks = 0;
    int                        sat_hits = 0;
    logic [31:0]               rnd = 32'hd411_8c91;

    threat_classifier_top UUT (
        .clk                (clk),
        .rst_n              (rst_n),
        .volt_anomaly       (flags.volt),
        .curr_anomaly       (flags.curr),
        .glitch_detected    (flags.glitch),
        .clk_glitch         (flags.clk_glitch),
        .freq_drift         (flags.freq_drift),
        .temp_hi_anomaly    (flags.temp_hi),
        .temp_lo_anomaly    (flags.temp_lo),
        .temp_roc_alert     (flags.temp_roc),
        .ipc_anomaly        (flags.ipc),
        .pc_jump_anomaly    (flags.pc_jump),
        .priv_anomaly       (flags.priv),
        .mem_oob_anomaly    (flags.mem_oob),
        .flush_anomaly      (flags.flush),
        .nmi_anomaly        (flags.nmi),
        .fused_score        (fused_score),
        .correlated_attack  (correlated_attack),
        .multi_domain_alert (multi_domain_alert),
        .threat_level       (threat_level),
        .attack_type        (attack_type),
        .threat_score       (threat_score),
        .threat_valid       (threat_valid),
        .threat_upgraded    (threat_upgraded),
        .threat_cleared     (threat_cleared)
    );

    bind threat_classifier_top threat_classifier_assert u_assert (
        .clk             (clk),
        .rst_n           (rst_n),
        .threat_level    (threat_level),
        .attack_type     (attack_type),
        .threat_valid    (threat_valid),
        .threat_upgraded (threat_upgraded),
        .threat_cleared  (threat_cleared)
    );

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==============================
    // Reference model
    // ==============================

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic kavach_pkg::score_t ref_score(input flags_t f,
            input kavach_pkg::score_t fused, input logic corr, input logic multi);
        int sum;
        sum = int'(fused);
        if (f.priv)       sum += int'(kavach_pkg::W_PRIV);
        if (f.glitch)     sum += int'(kavach_pkg::W_GLITCH);
        if (f.clk_glitch) sum += int'(kavach_pkg::W_CLK_GLITCH);
        if (f.pc_jump)    sum += int'(kavach_pkg::W_PC_JUMP);
        if (f.mem_oob)    sum += int'(kavach_pkg::W_MEM_OOB);
        if (f.nmi)        sum += int'(kavach_pkg::W_NMI);
        if (f.volt)       sum += int'(kavach_pkg::W_VOLT);
        if (f.curr)       sum += int'(kavach_pkg::W_CURR);
        if (f.temp_hi)    sum += int'(kavach_pkg::W_TEMP_HI);
        if (f.temp_lo)    sum += int'(kavach_pkg::W_TEMP_LO);
        if (f.freq_drift) sum += int'(kavach_pkg::W_FREQ);
        if (f.ipc)        sum += int'(kavach_pkg::W_IPC);
        if (f.flush)      sum += int'(kavach_pkg::W_FLUSH);
        if (f.temp_roc)   sum += int'(kavach_pkg::W_TEMP_ROC);
        if (corr)         sum += int'(kavach_pkg::W_CORRELATED);
        if (multi)        sum += int'(kavach_pkg::W_MULTI);
        // Clamp at the ceiling
        if (sum > int'(kavach_pkg::SCORE_MAX)) sum = int'(kavach_pkg::SCORE_MAX);
        return kavach_pkg::score_t'(sum);
    endfunction

    // First match wins
    function automatic kavach_pkg::attack_type_e ref_attack(input flags_t f,
            input logic corr, input logic multi);
        if (corr || multi)                  return kavach_pkg::AT_COMBINED;
        if (f.priv || f.pc_jump)            return kavach_pkg::AT_FAULT_INJ;
        if (f.glitch || (f.volt && f.curr)) return kavach_pkg::AT_PWR_GLITCH;
        if (f.clk_glitch || f.freq_drift)   return kavach_pkg::AT_CLK_ATTACK;
        if (f.temp_hi || f.temp_lo)         return kavach_pkg::AT_THERMAL;
        if (f.ipc)                          return kavach_pkg::AT_SIDE_CH;
        return kavach_pkg::AT_NONE;
    endfunction

    // ==============================
    // Compare tasks
    // ==============================

    task automatic check_score(input kavach_pkg::score_t act, input kavach_pkg::score_t exp,
            input string name);
        checks++;
        if (act !== exp) begin
            $display("Error at %0t ns: %s = %0d, expected %0d", $time, name, act, exp);
            errors++;
        end
    endtask

    task automatic check_attack(input kavach_pkg::attack_type_e act,
            input kavach_pkg::attack_type_e exp, input string name);
        checks++;
        if (act !== exp) begin
            $display("Error at %0t ns: %s = %0d, expected %0d", $time, name, act, exp);
            errors++;
        end
    endtask

    task automatic check_level(input kavach_pkg::threat_level_e act,
            input kavach_pkg::threat_level_e exp, input string name);
        checks++;
        if (act !== exp) begin
            $display("Error at %0t ns: %s = %0d, expected %0d", $time, name, act, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input logic act, input logic exp, input string name);
        checks++;
        if (act !== exp) begin
            $display("Error at %0t ns: %s = %b, expected %b", $time, name, act, exp);
            errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("At %0t ns: %s", $time, msg);
        errors++;
    endtask

    // Score and attack code, one cycle behind the inputs
    always @(negedge clk) begin
        if (prev_ok && rst_n) begin
            check_score(threat_score, ref_score(prev_flags, prev_fused, prev_corr, prev_multi),
                        "threat_score");
            check_attack(attack_type, ref_attack(prev_flags, prev_corr, prev_multi),
                         "attack_type");
            if (threat_score == kavach_pkg::SCORE_MAX) sat_hits++;
        end
        prev_ok    = rst_n;
        prev_flags = flags;
        prev_fused = fused_score;
        prev_corr  = correlated_attack;
        prev_multi = multi_domain_alert;
    end

    // ==============================
    // Stimulus helpers
    // ==============================

    task automatic wait_cycles(input int n);
        int k;
        for (k = 0; k < n; k++) begin
            @(posedge clk);
        end
    endtask

    // Pulse reset and clear every input
    task automatic apply_reset;
        @(posedge clk);
        rst_n              <= 1'b0;
        flags              <= '0;
        fused_score        <= '0;
        correlated_attack  <= 1'b0;
        multi_domain_alert <= 1'b0;
        wait_cycles(5);
        rst_n <= 1'b1;
    endtask

    task automatic attack_case(input flags_t f, input logic corr, input logic multi,
            input kavach_pkg::attack_type_e exp);
        @(posedge clk);
        flags              <= f;
        correlated_attack  <= corr;
        multi_domain_alert <= multi;
        @(posedge clk);
        @(negedge clk);
        check_attack(attack_type, exp, "attack_type");
    endtask

    // Level three cycles after a start from IDLE
    task automatic level_case(input kavach_pkg::score_t fused, input flags_t f,
            input kavach_pkg::threat_level_e exp);
        apply_reset();
        @(posedge clk);
        fused_score <= fused;
        flags       <= f;
        wait_cycles(3);
        @(negedge clk);
        check_level(threat_level, exp, "threat_level");
        check_bit(threat_valid, 1'b1, "threat_valid");
    endtask

    task automatic count_upgrades(input int n, output int pulses);
        int k;
        pulses = 0;
        for (k = 0; k < n; k++) begin
            @(negedge clk);
            if (threat_upgraded) pulses++;
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin : stimulus
        int          i;
        int          pulses;
        logic        done;
        logic [13:0] mask;
        rst_n              = 1'b0;
        flags              = '0;
        fused_score        = '0;
        correlated_attack  = 1'b0;
        multi_domain_alert = 1'b0;
        apply_reset();

        // Sparse random flags, rare fusion qualifiers
        for (i = 0; i < 200; i++) begin
            @(posedge clk);
            rnd  = lcg_next(rnd);
            mask = rnd[31:18];
            rnd  = lcg_next(rnd);
            flags <= flags_t'(mask & rnd[31:18]);
            rnd  = lcg_next(rnd);
            fused_score        <= rnd[31:24] >> rnd[22:21];
            correlated_attack  <= (rnd[17:15] == 3'd0);
            multi_domain_alert <= (rnd[14:12] == 3'd0);
        end
        wait_cycles(2);
        if (sat_hits == 0) report_failure("random stream never reached score saturation");

        // Priority pairs
        attack_case(flags_t'{priv: 1'b1, default: 1'b0}, 1'b1, 1'b0, kavach_pkg::AT_COMBINED);
        attack_case(flags_t'{glitch: 1'b1, default: 1'b0}, 1'b0, 1'b1, kavach_pkg::AT_COMBINED);
        attack_case(flags_t'{priv: 1'b1, glitch: 1'b1, default: 1'b0}, 1'b0, 1'b0,
                    kavach_pkg::AT_FAULT_INJ);
        attack_case(flags_t'{pc_jump: 1'b1, clk_glitch: 1'b1, default: 1'b0}, 1'b0, 1'b0,
                    kavach_pkg::AT_FAULT_INJ);
        attack_case(flags_t'{volt: 1'b1, curr: 1'b1, clk_glitch: 1'b1, default: 1'b0},
                    1'b0, 1'b0, kavach_pkg::AT_PWR_GLITCH);
        attack_case(flags_t'{volt: 1'b1, default: 1'b0}, 1'b0, 1'b0, kavach_pkg::AT_NONE);
        attack_case(flags_t'{freq_drift: 1'b1, temp_lo: 1'b1, default: 1'b0}, 1'b0, 1'b0,
                    kavach_pkg::AT_CLK_ATTACK);
        attack_case(flags_t'{temp_hi: 1'b1, ipc: 1'b1, default: 1'b0}, 1'b0, 1'b0,
                    kavach_pkg::AT_THERMAL);
        attack_case(flags_t'{ipc: 1'b1, flush: 1'b1, default: 1'b0}, 1'b0, 1'b0,
                    kavach_pkg::AT_SIDE_CH);
        attack_case(flags_t'{nmi: 1'b1, mem_oob: 1'b1, temp_roc: 1'b1, default: 1'b0},
                    1'b0, 1'b0, kavach_pkg::AT_NONE);

        // Steady scores, then priv override
        level_case(8'd30, '0, kavach_pkg::LVL_LOW);
        level_case(8'd70, '0, kavach_pkg::LVL_MEDIUM);
        level_case(8'd130, '0, kavach_pkg::LVL_HIGH);
        level_case(8'd210, '0, kavach_pkg::LVL_CRITICAL);
        level_case(8'd0, flags_t'{priv: 1'b1, default: 1'b0}, kavach_pkg::LVL_CRITICAL);

        // Hold at MEDIUM, then fall back to NONE
        level_case(8'd70, '0, kavach_pkg::LVL_MEDIUM);
        @(posedge clk);
        fused_score <= 8'd0;
        wait_cycles(3);
        @(negedge clk);
        check_level(threat_level, kavach_pkg::LVL_MEDIUM, "threat_level");
        check_bit(threat_valid, 1'b0, "threat_valid");
        done   = 1'b0;
        pulses = 0;
        for (i = 0; i < 40 && !done; i++) begin
            @(negedge clk);
            if (threat_cleared) pulses++;
            if (threat_level == kavach_pkg::LVL_NONE) done = 1'b1;
            else check_level(threat_level, kavach_pkg::LVL_MEDIUM, "threat_level");
        end
        if (!done) report_failure("threat_level did not return to NONE within 40 cycles");
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            if (threat_cleared) pulses++;
        end
        if (pulses != 1) report_failure($sformatf("threat_cleared pulsed %0d times", pulses));

        // LOW to HIGH, then steady, then lowered
        level_case(8'd30, '0, kavach_pkg::LVL_LOW);
        @(posedge clk);
        fused_score <= 8'd130;
        count_upgrades(8, pulses);
        check_level(threat_level, kavach_pkg::LVL_HIGH, "threat_level");
        if (pulses != 1) report_failure($sformatf("upgrade on rise lasted %0d cycles", pulses));
        count_upgrades(8, pulses);
        if (pulses != 0) report_failure("threat_upgraded pulsed with a steady score");
        @(posedge clk);
        fused_score <= 8'd70;
        count_upgrades(8, pulses);
        if (pulses != 0) report_failure("threat_upgraded pulsed on a lowered score");

        wait_cycles(2);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
source/kavach_pkg.sv
source/anomaly_if.sv
source/threat_scorer.sv
source/attack_typer.sv
source/threat_level_fsm.sv
source/threat_classifier_top.sv
tb/threat_classifier_assert.sv
tb/tb_threat_classifier.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_threat_classifier -f build.f -o sim_tb

output=$(./obj_dir/sim_tb 2>&1) || true
echo "$output"

if grep -q "Simulation completed successfully" <<< "$output"; then
    exit 0
fi
exit 1
